// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= regbus_tb
RTL_TOP   ?= regbus_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TB_TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: hdl/axil_port_decode.sv
/*
  axi4-lite slave front end for one master port
  gathers aw+w or ar into one request word and holds it
  until the matching b or r handshake is reported back
*/

`timescale 1ns/10ps

`include "regbus_settings.svh"

module axil_port_decode
  import regbus_types_pkg::*;
  import regbus_ctrl_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  // axi4-lite write address and data
  input  logic  awvalid_i,
  output logic  awready_o,
  input  addr_t awaddr_i,
  input  logic  wvalid_i,
  output logic  wready_o,
  input  data_t wdata_i,
  input  strb_t wstrb_i,
  // axi4-lite read address
  input  logic  arvalid_i,
  output logic  arready_o,
  input  addr_t araddr_i,
  // towards the arbiter
  output logic  req_valid_o,
  output req_t  req_o,
  input  logic  gnt_i,
  // b or r handshake done for this port
  input  logic  done_i
);

  dec_state_e state_q, state_d;
  // front end stays closed until the first edge after reset
  logic armed_q;
  logic have_aw_q, have_aw_d;
  logic have_w_q, have_w_d;
  logic aw_hs, w_hs, ar_hs;

  // held request payload
  op_e   op_q;
  addr_t addr_q;
  data_t wdata_q;
  strb_t strb_q;
  logic [`REGBUS_ADDR_W-3:0] word_addr;

  ////////////////////////////////////////////////////////////
  // channel readies
  ////////////////////////////////////////////////////////////

  always_comb begin
    awready_o = 1'b0;
    wready_o  = 1'b0;
    arready_o = 1'b0;
    case (state_q)
      DEC_IDLE: begin
        awready_o = armed_q;
        wready_o  = armed_q;
        // a write on the bus wins over a read in the same cycle
        arready_o = armed_q & ~awvalid_i & ~wvalid_i;
      end
      DEC_COLLECT: begin
        awready_o = ~have_aw_q;
        wready_o  = ~have_w_q;
      end
      default: ;
    endcase
  end

  assign aw_hs = awvalid_i & awready_o;
  assign w_hs  = wvalid_i & wready_o;
  assign ar_hs = arvalid_i & arready_o;

  ////////////////////////////////////////////////////////////
  // fsm
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    have_aw_d = have_aw_q;
    have_w_d  = have_w_q;
    case (state_q)
      DEC_IDLE: begin
        have_aw_d = aw_hs;
        have_w_d  = w_hs;
        if (aw_hs && w_hs) begin
          state_d = DEC_REQ;
        end else if (aw_hs || w_hs) begin
          state_d = DEC_COLLECT;
        end else if (ar_hs) begin
          state_d = DEC_REQ;
        end
      end
      DEC_COLLECT: begin
        // aw and w may come in either order
        have_aw_d = have_aw_q | aw_hs;
        have_w_d  = have_w_q | w_hs;
        if (have_aw_d && have_w_d) begin
          state_d = DEC_REQ;
        end
      end
      DEC_REQ: begin
        if (gnt_i) begin
          state_d = DEC_WAIT;
        end
      end
      DEC_WAIT: begin
        if (done_i) begin
          state_d = DEC_IDLE;
        end
      end
      default: state_d = DEC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= DEC_IDLE;
      armed_q   <= 1'b0;
      have_aw_q <= 1'b0;
      have_w_q  <= 1'b0;
    end else begin
      state_q   <= state_d;
      armed_q   <= 1'b1;
      have_aw_q <= have_aw_d;
      have_w_q  <= have_w_d;
    end
  end

  // aw and ar never complete in the same cycle
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      addr_q <= awaddr_i;
    end else if (ar_hs) begin
      addr_q <= araddr_i;
    end
    if (w_hs) begin
      wdata_q <= wdata_i;
      strb_q  <= wstrb_i;
    end
    if (aw_hs || w_hs) begin
      op_q <= OP_WRITE;
    end else if (ar_hs) begin
      op_q <= OP_READ;
    end
  end

  ////////////////////////////////////////////////////////////
  // request word
  ////////////////////////////////////////////////////////////

  // byte address to word address, the only range check in the design
  assign word_addr = addr_q[`REGBUS_ADDR_W-1:2];

  always_comb begin
    req_o.op    = op_q;
    req_o.idx   = word_addr[$bits(reg_idx_t)-1:0];
    req_o.oor   = (word_addr >= `REGBUS_NUM_REGS);
    req_o.wdata = wdata_q;
    req_o.strb  = strb_q;
  end

  // held stable until granted, the arbiter lock relies on it
  assign req_valid_o = (state_q == DEC_REQ);

endmodule

// File: hdl/axil_result_route.sv
/*
  result router
  steers the held response onto one port's b or r channel
  and reports the finished handshake back to that port
*/

`timescale 1ns/10ps

`include "regbus_settings.svh"

module axil_result_route
  import regbus_types_pkg::*;
  import regbus_ctrl_pkg::*;
(
  regbus_rsp_if.sink                       rsp,
  // per-port b channel
  output logic [`REGBUS_NUM_PORTS-1:0]      bvalid_o,
  input  logic [`REGBUS_NUM_PORTS-1:0]      bready_i,
  output axi_resp_e [`REGBUS_NUM_PORTS-1:0] bresp_o,
  // per-port r channel
  output logic [`REGBUS_NUM_PORTS-1:0]      rvalid_o,
  input  logic [`REGBUS_NUM_PORTS-1:0]      rready_i,
  output data_t [`REGBUS_NUM_PORTS-1:0]     rdata_o,
  output axi_resp_e [`REGBUS_NUM_PORTS-1:0] rresp_o,
  // one-hot completion to the decoders
  output logic [`REGBUS_NUM_PORTS-1:0]      done_o
);

  logic sel_ready;

  always_comb begin
    bvalid_o  = '0;
    rvalid_o  = '0;
    rdata_o   = '0;
    done_o    = '0;
    sel_ready = 1'b0;
    // idle channels show okay and zero data
    for (int p = 0; p < `REGBUS_NUM_PORTS; p++) begin
      bresp_o[p] = RESP_OKAY;
      rresp_o[p] = RESP_OKAY;
    end
    if (rsp.op == OP_WRITE) begin
      bvalid_o[rsp.idx] = rsp.valid;
      bresp_o[rsp.idx]  = rsp.resp;
      sel_ready         = bready_i[rsp.idx];
    end else begin
      rvalid_o[rsp.idx] = rsp.valid;
      rdata_o[rsp.idx]  = rsp.data;
      rresp_o[rsp.idx]  = rsp.resp;
      sel_ready         = rready_i[rsp.idx];
    end
    done_o[rsp.idx] = rsp.valid & sel_ready;
  end

  assign rsp.ready = sel_ready;

endmodule

// File: hdl/reg_execute.sv
/*
  register bank execute stage
  applies the granted strobed write or read
  and holds one response for the result router
*/

`timescale 1ns/10ps

`include "regbus_settings.svh"

module reg_execute
  import regbus_types_pkg::*;
  import regbus_ctrl_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  regbus_req_if.sink   req,
  regbus_rsp_if.source rsp
);

  data_t bank_q [`REGBUS_NUM_REGS];

  logic accept;
  logic do_write;

  // one-deep response register
  logic      rsp_valid_q;
  op_e       rsp_op_q;
  data_t     rsp_data_q;
  axi_resp_e rsp_resp_q;
  port_idx_t rsp_idx_q;

  // free slot, or the slot drains this cycle
  assign req.ready = ~rsp_valid_q | rsp.ready;
  assign accept    = req.valid & req.ready;
  // out-of-range requests leave the bank alone
  assign do_write  = accept & (req.req.op == OP_WRITE) & ~req.req.oor;

  ////////////////////////////////////////////////////////////
  // register bank
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < `REGBUS_NUM_REGS; r++) begin
        bank_q[r] <= '0;
      end
    end else if (do_write) begin
      // byte lanes with their strobe set
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (req.req.strb[b]) begin
          bank_q[req.req.idx][8*b +: 8] <= req.req.wdata[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // response register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp.ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_op_q   <= req.req.op;
      rsp_idx_q  <= req.idx;
      rsp_resp_q <= req.req.oor ? RESP_SLVERR : RESP_OKAY;
      // reads only, zero for writes and for slverr
      if (req.req.op == OP_READ && !req.req.oor) begin
        rsp_data_q <= bank_q[req.req.idx];
      end else begin
        rsp_data_q <= '0;
      end
    end
  end

  assign rsp.valid = rsp_valid_q;
  assign rsp.op    = rsp_op_q;
  assign rsp.data  = rsp_data_q;
  assign rsp.resp  = rsp_resp_q;
  assign rsp.idx   = rsp_idx_q;

endmodule

// File: hdl/regbus_ctrl_pkg.sv
/*
  register bank control types
  operation kind, axi response codes, decoder states
*/

`include "regbus_settings.svh"

package regbus_ctrl_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // only the two codes this slave can return
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // collect means one of aw or w is held, the other still missing
  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_COLLECT,
    DEC_REQ,
    DEC_WAIT
  } dec_state_e;

endpackage

// File: hdl/regbus_if.sv
/*
  internal request and response paths of the register bank
  request: arbiter output to execute stage
  response: execute stage to result router
*/

`timescale 1ns/10ps

interface regbus_req_if
  import regbus_types_pkg::*;
();
  logic      valid;
  logic      ready;
  req_t      req;
  // port that issued the request
  port_idx_t idx;

  modport source (output valid, output req, output idx, input ready);
  modport sink   (input valid, input req, input idx, output ready);
endinterface

interface regbus_rsp_if
  import regbus_types_pkg::*;
  import regbus_ctrl_pkg::*;
();
  logic      valid;
  logic      ready;
  // selects b or r channel
  op_e       op;
  // read data, zero for writes
  data_t     data;
  axi_resp_e resp;
  port_idx_t idx;

  modport source (output valid, output op, output data, output resp, output idx,
                  input ready);
  modport sink   (input valid, input op, input data, input resp, input idx,
                  output ready);
endinterface

// File: hdl/regbus_settings.svh
/*
  shared register bank settings
  port count, bus widths and bank depth
*/

`ifndef REGBUS_SETTINGS_SVH
`define REGBUS_SETTINGS_SVH

// number of axi4-lite master ports, 2 to 4
`define REGBUS_NUM_PORTS 4

// byte address width on every port
`define REGBUS_ADDR_W 8

// register and bus data width
`define REGBUS_DATA_W 32

// 32-bit registers in the bank, higher word indices answer SLVERR
`define REGBUS_NUM_REGS 16

`endif

// File: hdl/regbus_top.sv
/*
  shared register bank for several axi4-lite masters
  per-port decoders, round-robin arbiter, execute and result stages
*/

`timescale 1ns/10ps

`include "regbus_settings.svh"

module regbus_top
  import regbus_types_pkg::*;
  import regbus_ctrl_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // write address
  input  logic [`REGBUS_NUM_PORTS-1:0]      s_awvalid_i,
  output logic [`REGBUS_NUM_PORTS-1:0]      s_awready_o,
  input  addr_t [`REGBUS_NUM_PORTS-1:0]     s_awaddr_i,
  // write data
  input  logic [`REGBUS_NUM_PORTS-1:0]      s_wvalid_i,
  output logic [`REGBUS_NUM_PORTS-1:0]      s_wready_o,
  input  data_t [`REGBUS_NUM_PORTS-1:0]     s_wdata_i,
  input  strb_t [`REGBUS_NUM_PORTS-1:0]     s_wstrb_i,
  // write response
  output logic [`REGBUS_NUM_PORTS-1:0]      s_bvalid_o,
  input  logic [`REGBUS_NUM_PORTS-1:0]      s_bready_i,
  output axi_resp_e [`REGBUS_NUM_PORTS-1:0] s_bresp_o,
  // read address
  input  logic [`REGBUS_NUM_PORTS-1:0]      s_arvalid_i,
  output logic [`REGBUS_NUM_PORTS-1:0]      s_arready_o,
  input  addr_t [`REGBUS_NUM_PORTS-1:0]     s_araddr_i,
  // read data
  output logic [`REGBUS_NUM_PORTS-1:0]      s_rvalid_o,
  input  logic [`REGBUS_NUM_PORTS-1:0]      s_rready_i,
  output data_t [`REGBUS_NUM_PORTS-1:0]     s_rdata_o,
  output axi_resp_e [`REGBUS_NUM_PORTS-1:0] s_rresp_o
);

  logic [`REGBUS_NUM_PORTS-1:0] dec_valid;
  logic [`REGBUS_NUM_PORTS-1:0] dec_gnt;
  logic [`REGBUS_NUM_PORTS-1:0] dec_done;
  req_t [`REGBUS_NUM_PORTS-1:0] dec_req;

  regbus_req_if req_bus ();
  regbus_rsp_if rsp_bus ();

  // one front end per master
  for (genvar p = 0; p < `REGBUS_NUM_PORTS; p++) begin : gen_port
    axil_port_decode i_decode (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .awvalid_i   (s_awvalid_i[p]),
      .awready_o   (s_awready_o[p]),
      .awaddr_i    (s_awaddr_i[p]),
      .wvalid_i    (s_wvalid_i[p]),
      .wready_o    (s_wready_o[p]),
      .wdata_i     (s_wdata_i[p]),
      .wstrb_i     (s_wstrb_i[p]),
      .arvalid_i   (s_arvalid_i[p]),
      .arready_o   (s_arready_o[p]),
      .araddr_i    (s_araddr_i[p]),
      .req_valid_o (dec_valid[p]),
      .req_o       (dec_req[p]),
      .gnt_i       (dec_gnt[p]),
      .done_i      (dec_done[p])
    );
  end

  rr_arb_tree #(
    .NUM_IN (`REGBUS_NUM_PORTS),
    .DATA_T (req_t)
  ) i_arb (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (dec_valid),
    .gnt_o  (dec_gnt),
    .data_i (dec_req),
    .req_o  (req_bus.valid),
    .gnt_i  (req_bus.ready),
    .data_o (req_bus.req),
    .idx_o  (req_bus.idx)
  );

  reg_execute i_execute (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req    (req_bus.sink),
    .rsp    (rsp_bus.source)
  );

  axil_result_route i_route (
    .rsp      (rsp_bus.sink),
    .bvalid_o (s_bvalid_o),
    .bready_i (s_bready_i),
    .bresp_o  (s_bresp_o),
    .rvalid_o (s_rvalid_o),
    .rready_i (s_rready_i),
    .rdata_o  (s_rdata_o),
    .rresp_o  (s_rresp_o),
    .done_o   (dec_done)
  );

endmodule

// File: hdl/regbus_types_pkg.sv
/*
  register bank data-path types
  address, data, strobe, indices and the request word
*/

`include "regbus_settings.svh"

package regbus_types_pkg;
  import regbus_ctrl_pkg::*;

  // bus fields
  typedef logic [`REGBUS_ADDR_W-1:0]   addr_t;
  typedef logic [`REGBUS_DATA_W-1:0]   data_t;
  typedef logic [`REGBUS_DATA_W/8-1:0] strb_t;

  // word index into the bank and master port number
  typedef logic [$clog2(`REGBUS_NUM_REGS)-1:0]  reg_idx_t;
  typedef logic [$clog2(`REGBUS_NUM_PORTS)-1:0] port_idx_t;

  // one request as it travels through the arbiter, 42 bits
  typedef struct packed {
    op_e      op;
    reg_idx_t idx;
    // word index at or above the bank size
    logic     oor;
    data_t    wdata;
    strb_t    strb;
  } req_t;

endpackage

// File: hdl/rr_arb_tree.sv
/*
  logarithmic round-robin arbitration tree with lock-in
  picks one request, forwards its data and index,
  and returns the grant to the winning input
*/

`timescale 1ns/10ps

module rr_arb_tree #(
  parameter int unsigned NUM_IN = 4,
  parameter type         DATA_T = logic [31:0],
  localparam int unsigned IDX_W = (NUM_IN > 1) ? $clog2(NUM_IN) : 1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // requesters
  input  logic [NUM_IN-1:0]     req_i,
  output logic [NUM_IN-1:0]     gnt_o,
  input  DATA_T [NUM_IN-1:0]    data_i,
  // arbitrated output, valid/ready style
  output logic                  req_o,
  input  logic                  gnt_i,
  output DATA_T                 data_o,
  output logic [IDX_W-1:0]      idx_o
);

  if (NUM_IN == 1) begin : gen_pass
    // single requester, nothing to choose
    assign req_o    = req_i[0];
    assign gnt_o[0] = gnt_i;
    assign data_o   = data_i[0];
    assign idx_o    = '0;
  end else begin : gen_tree
    localparam int unsigned LEVELS = $clog2(NUM_IN);
    // leaf count padded to a power of two
    localparam int unsigned LEAVES = 2**LEVELS;
    localparam int unsigned NODES  = 2*LEAVES - 1;

    logic [LEVELS-1:0] rr_q, rr_d;
    logic              lock_q;
    logic [NUM_IN-1:0] req_q, req_d;

    //////////////////////////////////////////////////////////
    // lock-in and rotating pointer
    //////////////////////////////////////////////////////////

    // a pending but ungranted output freezes the request set
    assign req_d = lock_q ? req_q : req_i;

    // step only when the output is taken
    assign rr_d = (req_o && gnt_i) ?
                  ((rr_q == LEVELS'(NUM_IN-1)) ? '0 : rr_q + 1'b1) : rr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rr_q   <= '0;
        lock_q <= 1'b0;
        req_q  <= '0;
      end else begin
        rr_q   <= rr_d;
        lock_q <= req_o & ~gnt_i;
        req_q  <= req_d;
      end
    end

    //////////////////////////////////////////////////////////
    // selector tree
    //////////////////////////////////////////////////////////

    // heap order, node 0 is the root, children of n are 2n+1 and 2n+2
    always_comb begin : p_tree
      logic [LEAVES-1:0]            req_pad;
      DATA_T [LEAVES-1:0]           data_pad;
      logic [NODES-1:0]             n_req;
      logic [NODES-1:0]             n_gnt;
      logic [LEAVES-2:0]            n_sel;
      logic [NODES-1:0][IDX_W-1:0]  n_idx;
      DATA_T [NODES-1:0]            n_data;
      int unsigned                  n;

      req_pad                = '0;
      req_pad[NUM_IN-1:0]    = req_d;
      data_pad               = '0;
      data_pad[NUM_IN-1:0]   = data_i;

      // leaves
      for (int unsigned i = 0; i < LEAVES; i++) begin
        n_req[LEAVES-1+i]  = req_pad[i];
        n_data[LEAVES-1+i] = data_pad[i];
        n_idx[LEAVES-1+i]  = IDX_W'(i);
      end

      // bottom up, one pointer bit per level, root takes the msb
      for (int lvl = LEVELS-1; lvl >= 0; lvl--) begin
        for (int p = 0; p < (1 << lvl); p++) begin
          n = (1 << lvl) - 1 + p;
          // right wins if left is idle, or both ask and the bit is set
          n_sel[n]  = ~n_req[2*n+1] | (n_req[2*n+2] & rr_q[LEVELS-1-lvl]);
          n_req[n]  = n_req[2*n+1] | n_req[2*n+2];
          n_idx[n]  = n_sel[n] ? n_idx[2*n+2] : n_idx[2*n+1];
          n_data[n] = n_sel[n] ? n_data[2*n+2] : n_data[2*n+1];
        end
      end

      // grant walks back down the chosen path
      n_gnt[0] = gnt_i;
      for (int unsigned m = 0; m < LEAVES-1; m++) begin
        n_gnt[2*m+1] = n_gnt[m] & ~n_sel[m];
        n_gnt[2*m+2] = n_gnt[m] & n_sel[m];
      end

      for (int unsigned i = 0; i < NUM_IN; i++) begin
        gnt_o[i] = n_gnt[LEAVES-1+i] & req_d[i];
      end

      req_o  = n_req[0];
      data_o = n_data[0];
      idx_o  = n_idx[0];
    end
  end

endmodule

// File: src.f
+incdir+hdl
hdl/regbus_ctrl_pkg.sv
hdl/regbus_types_pkg.sv
hdl/regbus_if.sv
hdl/axil_port_decode.sv
hdl/rr_arb_tree.sv
hdl/reg_execute.sv
hdl/axil_result_route.sv
hdl/regbus_top.sv
test/regbus_checker.sv
test/regbus_tb.sv

// File: test/regbus_checker.sv
/*
  response checker for the shared register bank
  watches every port's b and r channel, compares each handshake
  with the expected entry and keeps pass and error counts
*/

`timescale 1ns/10ps

`include "regbus_settings.svh"

module regbus_checker
  import regbus_types_pkg::*;
  import regbus_ctrl_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [`REGBUS_NUM_PORTS-1:0]      bvalid_i,
  input  logic [`REGBUS_NUM_PORTS-1:0]      bready_i,
  input  axi_resp_e [`REGBUS_NUM_PORTS-1:0] bresp_i,
  input  logic [`REGBUS_NUM_PORTS-1:0]      rvalid_i,
  input  logic [`REGBUS_NUM_PORTS-1:0]      rready_i,
  input  data_t [`REGBUS_NUM_PORTS-1:0]     rdata_i,
  input  axi_resp_e [`REGBUS_NUM_PORTS-1:0] rresp_i
);

  localparam int NP = `REGBUS_NUM_PORTS;

  // one expected entry per port, a port has one transaction in flight
  string     exp_name [NP];
  logic      exp_pending [NP] = '{default: 1'b0};
  op_e       exp_op [NP];
  data_t     exp_data [NP];
  axi_resp_e exp_resp [NP];

  int pass_cnt = 0;
  int err_cnt  = 0;

  // r channel seen valid but not taken at the previous edge
  logic [NP-1:0] r_stall_q = '0;
  data_t [NP-1:0] rdata_q;

  task automatic expect_rsp(input string name, input int port, input op_e op,
                            input data_t data, input axi_resp_e resp);
    exp_name[port]    = name;
    exp_op[port]      = op;
    exp_data[port]    = data;
    exp_resp[port]    = resp;
    exp_pending[port] = 1'b1;
  endtask

  task automatic note_fail(input string what);
    $display("failure: %s", what);
    err_cnt++;
  endtask

  task automatic report();
    $display("tests passed %0d, errors %0d", pass_cnt, err_cnt);
  endtask

  // one handshake closes one test
  task automatic close_test(input int p, input op_e op, input data_t data,
                            input axi_resp_e resp);
    int errs;
    errs = 0;
    if (!exp_pending[p]) begin
      note_fail($sformatf("response on port %0d with no transaction pending", p));
      return;
    end
    exp_pending[p] = 1'b0;
    if (op != exp_op[p]) begin
      note_fail($sformatf("%s got a response on the wrong channel", exp_name[p]));
      return;
    end
    if (resp !== exp_resp[p]) begin
      $display("error: %s expected resp %0d actual resp %0d", exp_name[p], exp_resp[p], resp);
      errs++;
    end
    // b carries no data
    if (op == OP_READ && data !== exp_data[p]) begin
      $display("error: %s expected data %h actual data %h", exp_name[p], exp_data[p], data);
      errs++;
    end
    if (errs == 0) begin
      $display("ok: %s", exp_name[p]);
      pass_cnt++;
    end
    err_cnt += errs;
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      for (int p = 0; p < NP; p++) begin
        if (bvalid_i[p] && bready_i[p]) begin
          close_test(p, OP_WRITE, '0, bresp_i[p]);
        end
        if (rvalid_i[p] && rready_i[p]) begin
          close_test(p, OP_READ, rdata_i[p], rresp_i[p]);
        end
        // a stalled read must hold valid and data
        if (r_stall_q[p] && !rvalid_i[p]) begin
          note_fail($sformatf("rvalid on port %0d dropped before its handshake", p));
        end else if (r_stall_q[p] && rdata_i[p] !== rdata_q[p]) begin
          $display("error: %s stall expected data %h actual data %h",
                   exp_name[p], rdata_q[p], rdata_i[p]);
          err_cnt++;
        end
        r_stall_q[p] = rvalid_i[p] & ~rready_i[p];
        rdata_q[p]   = rdata_i[p];
      end
    end
  end

endmodule

// File: test/regbus_tb.sv
/*
  testbench for the shared register bank
  table driven axi4-lite traffic on all ports, checked by regbus_checker
*/

`timescale 1ns/10ps

`include "regbus_settings.svh"

module regbus_tb
  import regbus_types_pkg::*;
  import regbus_ctrl_pkg::*;
();

  localparam int NP    = `REGBUS_NUM_PORTS;
  localparam int NREGS = `REGBUS_NUM_REGS;
  localparam int MAX_T = 64;
  localparam int TMO   = 200;
  // entry kinds
  localparam int K_NORM    = 0;
  localparam int K_WFIRST  = 1;
  localparam int K_CONC    = 2;
  localparam int K_STALL   = 3;
  localparam int K_AWFIRST = 4;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic [NP-1:0]      s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
  logic [NP-1:0]      s_arvalid, s_arready, s_rvalid, s_rready;
  addr_t [NP-1:0]     s_awaddr, s_araddr;
  data_t [NP-1:0]     s_wdata, s_rdata;
  strb_t [NP-1:0]     s_wstrb;
  axi_resp_e [NP-1:0] s_bresp, s_rresp;

  // stimulus table
  string     t_name [MAX_T];
  int        t_port [MAX_T];
  op_e       t_op [MAX_T];
  addr_t     t_addr [MAX_T];
  data_t     t_wdata [MAX_T];
  strb_t     t_strb [MAX_T];
  data_t     t_exp_data [MAX_T];
  axi_resp_e t_exp_resp [MAX_T];
  int        t_kind [MAX_T];
  int        n_tests = 0;
  // expected bank contents while the table is built
  data_t     model [NREGS];

  always #50 clk_i = ~clk_i;

  regbus_top i_regbus_top (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .s_awvalid_i (s_awvalid), .s_awready_o (s_awready), .s_awaddr_i (s_awaddr),
    .s_wvalid_i (s_wvalid), .s_wready_o (s_wready), .s_wdata_i (s_wdata),
    .s_wstrb_i (s_wstrb), .s_bvalid_o (s_bvalid), .s_bready_i (s_bready),
    .s_bresp_o (s_bresp), .s_arvalid_i (s_arvalid), .s_arready_o (s_arready),
    .s_araddr_i (s_araddr), .s_rvalid_o (s_rvalid), .s_rready_i (s_rready),
    .s_rdata_o (s_rdata), .s_rresp_o (s_rresp)
  );

  regbus_checker i_checker (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .bvalid_i (s_bvalid), .bready_i (s_bready), .bresp_i (s_bresp),
    .rvalid_i (s_rvalid), .rready_i (s_rready), .rdata_i (s_rdata), .rresp_i (s_rresp)
  );

  // strobed bytes take the new value, the rest keep the old one
  function automatic data_t merge_bytes(data_t old_v, data_t new_v, strb_t strb);
    data_t res;
    res = old_v;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (strb[b]) res[8*b +: 8] = new_v[8*b +: 8];
    end
    return res;
  endfunction

  task automatic add_entry(input string name, input int port, input op_e op,
                           input addr_t addr, input data_t wdata, input strb_t strb,
                           input int kind);
    int widx;
    widx = int'(addr) / 4;
    t_name[n_tests]     = name;
    t_port[n_tests]     = port;
    t_op[n_tests]       = op;
    t_addr[n_tests]     = addr;
    t_wdata[n_tests]    = wdata;
    t_strb[n_tests]     = strb;
    t_kind[n_tests]     = kind;
    t_exp_resp[n_tests] = (widx < NREGS) ? RESP_OKAY : RESP_SLVERR;
    t_exp_data[n_tests] = '0;
    if (widx < NREGS && op == OP_WRITE) begin
      model[widx] = merge_bytes(model[widx], wdata, strb);
    end else if (widx < NREGS) begin
      t_exp_data[n_tests] = model[widx];
    end
    n_tests++;
  endtask

  task automatic build_table();
    for (int r = 0; r < NREGS; r++) model[r] = '0;
    // reset state, then w before aw against aw first
    for (int r = 0; r < NREGS; r++) begin
      add_entry($sformatf("reset_read_r%0d", r), r % NP, OP_READ, addr_t'(4*r), 0, 0, K_NORM);
    end
    add_entry("wfirst_write", 1 % NP, OP_WRITE, 8'h14, 32'hcafe_1234, 4'hf, K_WFIRST);
    add_entry("wfirst_read", 0, OP_READ, 8'h14, 0, 0, K_NORM);
    add_entry("awfirst_write", 1 % NP, OP_WRITE, 8'h18, 32'hcafe_1234, 4'hf, K_AWFIRST);
    add_entry("awfirst_read", 0, OP_READ, 8'h18, 0, 0, K_NORM);
    // write on port 0, read from another port
    add_entry("wr_full_p0", 0, OP_WRITE, 8'h08, 32'h1234_5678, 4'hf, K_NORM);
    add_entry("rd_back_p2", 2 % NP, OP_READ, 8'h08, 0, 0, K_NORM);
    // byte strobes
    add_entry("strb_full", 3 % NP, OP_WRITE, 8'h0c, 32'haabb_ccdd, 4'hf, K_NORM);
    add_entry("strb_lanes_0_2", 0, OP_WRITE, 8'h0c, 32'h1122_3344, 4'b0101, K_NORM);
    add_entry("strb_read", 1 % NP, OP_READ, 8'h0c, 0, 0, K_NORM);
    // out of range, bank must stay untouched
    add_entry("oor_write", 0, OP_WRITE, 8'h40, 32'hdead_beef, 4'hf, K_NORM);
    add_entry("oor_read", 1 % NP, OP_READ, 8'hfc, 0, 0, K_NORM);
    for (int r = 0; r < NREGS; r++) begin
      add_entry($sformatf("oor_check_r%0d", r), r % NP, OP_READ, addr_t'(4*r), 0, 0, K_NORM);
    end
    // all ports write in the same cycle
    for (int p = 0; p < NP; p++) begin
      add_entry($sformatf("conc_write_p%0d", p), p, OP_WRITE, addr_t'(8'h20 + 4*p),
                $urandom(), 4'hf, K_CONC);
    end
    for (int p = 0; p < NP; p++) begin
      add_entry($sformatf("conc_read_p%0d", p), (p + 1) % NP, OP_READ,
                addr_t'(8'h20 + 4*p), 0, 0, K_NORM);
    end
    // read stalled by rready, write issued during the stall
    add_entry("stall_read_p1", 1, OP_READ, 8'h08, 0, 0, K_STALL);
    add_entry("stall_write_p0", 0, OP_WRITE, 8'h30, 32'h5a5a_0f0f, 4'hf, K_NORM);
    add_entry("stall_final_read", 2 % NP, OP_READ, 8'h30, 0, 0, K_NORM);
  endtask

  task automatic wait_resp(input int p, input op_e op);
    int cnt;
    logic got;
    cnt = 0;
    got = 1'b0;
    while (!got && cnt < TMO) begin
      @(negedge clk_i);
      got = (op == OP_WRITE) ? (s_bvalid[p] & s_bready[p]) : (s_rvalid[p] & s_rready[p]);
      @(posedge clk_i);
      #10;
      cnt++;
    end
    if (!got) i_checker.note_fail($sformatf("no response arrived on port %0d", p));
  endtask

  task automatic write_txn(input int p, input addr_t addr, input data_t data,
                           input strb_t strb, input logic w_first, input logic aw_first);
    int cnt;
    logic aw_done, w_done, aw_go, w_go;
    cnt = 0;
    aw_done = 1'b0;
    w_done = 1'b0;
    @(posedge clk_i);
    #10;
    s_wvalid[p] = ~aw_first;
    s_wdata[p]  = data;
    s_wstrb[p]  = strb;
    s_awaddr[p] = addr;
    s_awvalid[p] = ~w_first;
    while (!(aw_done && w_done) && cnt < TMO) begin
      @(negedge clk_i);
      aw_go = s_awvalid[p] & s_awready[p];
      w_go  = s_wvalid[p] & s_wready[p];
      @(posedge clk_i);
      #10;
      if (aw_go) begin
        s_awvalid[p] = 1'b0;
        aw_done = 1'b1;
        // data follows once the address is taken
        if (!w_done && !w_go) s_wvalid[p] = 1'b1;
      end
      if (w_go) begin
        s_wvalid[p] = 1'b0;
        w_done = 1'b1;
        // address follows once the data is taken
        if (!aw_done) s_awvalid[p] = 1'b1;
      end
      cnt++;
    end
    if (!(aw_done && w_done)) begin
      i_checker.note_fail($sformatf("write address or data not accepted on port %0d", p));
      s_awvalid[p] = 1'b0;
      s_wvalid[p] = 1'b0;
    end else begin
      wait_resp(p, OP_WRITE);
    end
  endtask

  task automatic read_txn(input int p, input addr_t addr);
    int cnt;
    logic ar_go;
    cnt = 0;
    ar_go = 1'b0;
    @(posedge clk_i);
    #10;
    s_arvalid[p] = 1'b1;
    s_araddr[p]  = addr;
    while (!ar_go && cnt < TMO) begin
      @(negedge clk_i);
      ar_go = s_arready[p];
      @(posedge clk_i);
      #10;
      cnt++;
    end
    s_arvalid[p] = 1'b0;
    if (!ar_go) i_checker.note_fail($sformatf("read address not accepted on port %0d", p));
    else wait_resp(p, OP_READ);
  endtask

  task automatic run_entry(input int e);
    i_checker.expect_rsp(t_name[e], t_port[e], t_op[e], t_exp_data[e], t_exp_resp[e]);
    if (t_op[e] == OP_WRITE) begin
      write_txn(t_port[e], t_addr[e], t_wdata[e], t_strb[e], t_kind[e] == K_WFIRST,
                t_kind[e] == K_AWFIRST);
    end else begin
      read_txn(t_port[e], t_addr[e]);
    end
  endtask

  // read held back by rready while another port writes
  task automatic run_stall(input int e);
    int stall, cnt, p, wp;
    logic seen;
    p = t_port[e];
    wp = t_port[e+1];
    stall = 3 + ($urandom() % 6);
    cnt = 0;
    seen = 1'b0;
    s_rready[p] = 1'b0;
    fork
      run_entry(e);
    join_none
    while (!seen && cnt < TMO) begin
      @(negedge clk_i);
      seen = s_rvalid[p];
      cnt++;
    end
    if (!seen) i_checker.note_fail($sformatf("stalled read never became valid on port %0d", p));
    fork
      run_entry(e + 1);
    join_none
    repeat (stall) begin
      @(negedge clk_i);
      if (s_bvalid[wp]) i_checker.note_fail("write completed while the read was stalled");
    end
    @(posedge clk_i);
    #10;
    s_rready[p] = 1'b1;
    wait fork;
  endtask

  initial begin
    int i, n_conc;
    void'($urandom(32'h3893b971));
    rst_ni    = 1'b0;
    s_awvalid = '0;
    s_wvalid  = '0;
    s_arvalid = '0;
    s_awaddr  = '0;
    s_araddr  = '0;
    s_wdata   = '0;
    s_wstrb   = '0;
    s_bready  = '1;
    s_rready  = '1;
    build_table();
    repeat (10) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    // handshake outputs stay low until the first edge after reset
    #10;
    if (s_awready !== '0 || s_wready !== '0 || s_arready !== '0 ||
        s_bvalid !== '0 || s_rvalid !== '0) begin
      i_checker.note_fail("ready or valid output high before the first edge after reset");
    end
    @(posedge clk_i);
    #10;
    if (s_awready !== '1 || s_wready !== '1 || s_arready !== '1) begin
      i_checker.note_fail("ready outputs not high in idle after reset");
    end
    i = 0;
    while (i < n_tests) begin
      if (t_kind[i] == K_CONC) begin
        n_conc = 0;
        while (i + n_conc < n_tests && t_kind[i + n_conc] == K_CONC) n_conc++;
        for (int k = 0; k < n_conc; k++) begin
          fork
            automatic int e = i + k;
            run_entry(e);
          join_none
        end
        wait fork;
        i += n_conc;
      end else if (t_kind[i] == K_STALL) begin
        run_stall(i);
        i += 2;
      end else begin
        run_entry(i);
        i++;
      end
    end
    repeat (2) @(posedge clk_i);
    i_checker.report();
    if (i_checker.err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // overall run limit
  initial begin
    #2_000_000;
    $display("run limit reached before all tests finished");
    $display("Test failed");
    $finish;
  end

endmodule
